// ==== err_gen_consts.svh ====
/*
 * bus widths and limits of the error generator, shared by packages and RTL
 * CNT_WIDTH must be able to hold MAX_OUTSTANDING itself, not just MAX_OUTSTANDING-1
 */
`ifndef ERR_GEN_CONSTS_SVH
`define ERR_GEN_CONSTS_SVH

// --------------------
// bus widths
// --------------------
`define ADR_WIDTH 16         // address bus
`define DAT_WIDTH 16         // read and write data
`define SEL_WIDTH 2          // byte selects, one per byte of DAT_WIDTH

// --------------------
// target selection
// --------------------
`define TGT_CNT 4            // one-hot tag, all zero means no target

// --------------------
// outstanding tracking
// --------------------
`define MAX_OUTSTANDING 4    // forwarded requests awaiting a response
`define CNT_WIDTH 3          // 0..MAX_OUTSTANDING

`endif

// ==== wb_bus_pkg.sv ====
/*
 * field types of the pipelined Wishbone bus on both sides of the generator
 * widths follow err_gen_consts.svh
 */
`default_nettype none

`include "err_gen_consts.svh"

package wb_bus_pkg;

   // --------------------
   // request fields
   // --------------------
   typedef logic [`ADR_WIDTH-1:0] adr_t;    // byte address
   typedef logic [`DAT_WIDTH-1:0] dat_t;    // write data and read data
   typedef logic [`SEL_WIDTH-1:0] sel_t;    // byte lanes

   // one bit per target, forwarded unchanged with the request
   typedef logic [`TGT_CNT-1:0] tgtsel_t;   // zero tag is answered locally

endpackage

`default_nettype wire

// ==== err_gen_pkg.sv ====
/*
 * classification of the initiator cycle as seen by all generator stages
 * REQ_NONE covers idle cycles and cycles with cyc high but stb low
 */
`default_nettype none

package err_gen_pkg;

   // --------------------
   // request kind
   // --------------------
   typedef enum logic [1:0]
   {
      REQ_NONE    = 2'b00,    // no strobe this cycle
      REQ_VALID   = 2'b01,    // tag has a target, forward
      REQ_INVALID = 2'b10     // tag all zero, answer with err
   } req_kind_t;

   // 2'b11 is never produced by the decoder
   // the kind is combinational, it says nothing about acceptance
   // acceptance comes with the separate strobes of the decoder

endpackage

`default_nettype wire

// ==== wb_req_decode.sv ====
/*
 * combinational input stage, zero cycles from initiator to target
 * a valid request is held back from the target while the tracker is full
 * an invalid request is held while any forwarded request is outstanding
 */
`default_nettype none

module wb_req_decode
   import wb_bus_pkg::*;
   import err_gen_pkg::*;
(
   input  logic      itr_cyc_i,       // initiator bus cycle
   input  logic      itr_stb_i,       // initiator strobe
   input  logic      itr_we_i,        // write enable
   input  sel_t      itr_sel_i,       // byte selects
   input  adr_t      itr_adr_i,       // address
   input  dat_t      itr_dat_i,       // write data
   input  tgtsel_t   itr_tgtsel_i,    // one-hot target tag
   input  logic      tgt_stall_i,     // target back-pressure
   input  logic      busy_i,          // forwarded requests outstanding
   input  logic      full_i,          // outstanding limit reached
   output req_kind_t req_kind_o,      // class of this cycle
   output logic      fwd_accept_o,    // valid request taken by target
   output logic      inval_accept_o,  // invalid request taken locally
   output logic      itr_stall_o,     // back-pressure to initiator
   output logic      tgt_cyc_o,       // target bus cycle
   output logic      tgt_stb_o,       // target strobe
   output logic      tgt_we_o,
   output sel_t      tgt_sel_o,
   output adr_t      tgt_adr_o,
   output dat_t      tgt_dat_o,
   output tgtsel_t   tgt_tgtsel_o
);

   logic is_valid;                    // strobe with a target
   logic is_inval;                    // strobe without a target

   // --------------------
   // classification
   // --------------------
   always_comb
   begin
      if (!(itr_cyc_i && itr_stb_i))
         req_kind_o = REQ_NONE;
      else if (|itr_tgtsel_i)
         req_kind_o = REQ_VALID;
      else
         req_kind_o = REQ_INVALID;
   end

   assign is_valid = (req_kind_o == REQ_VALID);
   assign is_inval = (req_kind_o == REQ_INVALID);

   // --------------------
   // target side
   // --------------------
   // cyc stays up while responses are owed, even under an invalid strobe
   assign tgt_cyc_o    = itr_cyc_i & (is_valid | busy_i);
   assign tgt_stb_o    = is_valid & ~full_i;          // no strobe past the limit
   assign tgt_we_o     = itr_we_i;                    // payload passes unchanged
   assign tgt_sel_o    = itr_sel_i;
   assign tgt_adr_o    = itr_adr_i;
   assign tgt_dat_o    = itr_dat_i;
   assign tgt_tgtsel_o = itr_tgtsel_i;

   // --------------------
   // stall and accept
   // --------------------
   always_comb
   begin
      unique case (req_kind_o)
         REQ_VALID:   itr_stall_o = tgt_stall_i | full_i;
         REQ_INVALID: itr_stall_o = busy_i;           // wait for in-order slot
         default:     itr_stall_o = 1'b0;
      endcase
   end

   assign fwd_accept_o   = tgt_stb_o & ~tgt_stall_i;
   assign inval_accept_o = is_inval & ~busy_i;

endmodule

`default_nettype wire

// ==== wb_out_tracker.sv ====
/*
 * counts forwarded requests that still await ack, err or rty from the target
 * acceptance and response in the same cycle leave the count unchanged
 * the target must answer no earlier than the cycle after acceptance
 */
`default_nettype none

`include "err_gen_consts.svh"

module wb_out_tracker
   import err_gen_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,           // async, active high
   input  req_kind_t req_kind_i,      // class of current cycle
   input  logic      fwd_accept_i,    // request taken by target
   input  logic      tgt_ack_i,       // target acknowledge
   input  logic      tgt_err_i,       // target error
   input  logic      tgt_rty_i,       // target retry
   output logic      busy_o,          // count nonzero
   output logic      full_o           // count at the limit
);

   logic [`CNT_WIDTH-1:0] cnt_q;      // outstanding forwarded requests
   logic [`CNT_WIDTH-1:0] cnt_d;
   logic                  tgt_rsp;    // any target response this cycle

   assign tgt_rsp = tgt_ack_i | tgt_err_i | tgt_rty_i;

   // --------------------
   // next count
   // --------------------
   always_comb
   begin
      cnt_d = cnt_q;                                  // hold by default
      unique case ({fwd_accept_i, tgt_rsp})
         2'b10:   cnt_d = cnt_q + 1'b1;               // new request in flight
         2'b01:   cnt_d = cnt_q - 1'b1;               // one retired
         default: cnt_d = cnt_q;                      // none, or one in one out
      endcase
   end

   // --------------------
   // counter register
   // --------------------
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         cnt_q <= '0;
      end
      else
      begin
         cnt_q <= cnt_d;
      end
   end

   // --------------------
   // status
   // --------------------
   assign busy_o = (cnt_q != '0);
   assign full_o = (cnt_q == `CNT_WIDTH'(`MAX_OUTSTANDING));

   // the decoder masks the strobe when full, so the count stays bounded
   cnt_limit_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      cnt_q <= `CNT_WIDTH'(`MAX_OUTSTANDING))
      else $error("outstanding count above limit");

   // a response with nothing in flight, or in the acceptance cycle itself
   no_early_rsp_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      tgt_rsp |-> busy_o)
      else $error("target response without outstanding request");

   // only a request classified valid may be counted
   fwd_is_valid_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      fwd_accept_i |-> (req_kind_i == REQ_VALID))
      else $error("forwarded accept on non-valid request");

endmodule

`default_nettype wire

// ==== wb_rsp_merge.sv ====
/*
 * output stage, the generated err is registered one cycle after acceptance
 * ack, rty and read data pass through combinationally
 * read data is forced to zero while the generated err is shown
 */
`default_nettype none

module wb_rsp_merge
   import wb_bus_pkg::*;
   import err_gen_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,           // async, active high
   input  req_kind_t req_kind_i,      // class of current cycle
   input  logic      inval_accept_i,  // invalid request taken locally
   input  logic      tgt_ack_i,
   input  logic      tgt_err_i,
   input  logic      tgt_rty_i,
   input  dat_t      tgt_dat_i,       // target read data
   output logic      itr_ack_o,
   output logic      itr_err_o,
   output logic      itr_rty_o,
   output dat_t      itr_dat_o        // read data to initiator
);

   logic err_pend_q;                  // generated err due this cycle

   // --------------------
   // error pending
   // --------------------
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         err_pend_q <= 1'b0;
      end
      else
      begin
         err_pend_q <= inval_accept_i;                // one cycle per accept
      end
   end

   // --------------------
   // response merge
   // --------------------
   assign itr_ack_o = tgt_ack_i;
   assign itr_err_o = tgt_err_i | err_pend_q;
   assign itr_rty_o = tgt_rty_i;
   assign itr_dat_o = err_pend_q ? '0 : tgt_dat_i;   // no stale data on err

   // the busy stall in the decoder keeps both response sources apart
   no_rsp_clash_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      err_pend_q |-> !(tgt_ack_i || tgt_err_i || tgt_rty_i))
      else $error("generated err collides with target response");

   // local accept only for target-less requests
   inval_is_inval_a: assert property (
      @(posedge clk_i) disable iff (rst_i)
      inval_accept_i |-> (req_kind_i == REQ_INVALID))
      else $error("local accept on request with a target");

endmodule

`default_nettype wire

// ==== wb_err_gen.sv ====
/*
 * pipelined Wishbone error generator between one initiator and one target
 * requests with an all-zero target tag get err one cycle after acceptance
 * responses stay in order, a target-less request waits for the target to drain
 */
`default_nettype none

module wb_err_gen
   import wb_bus_pkg::*;
   import err_gen_pkg::*;
(
   input  logic    clk_i,
   input  logic    rst_i,             // async, active high
   // initiator side
   input  logic    itr_cyc_i,
   input  logic    itr_stb_i,
   input  logic    itr_we_i,
   input  sel_t    itr_sel_i,
   input  adr_t    itr_adr_i,
   input  dat_t    itr_dat_i,
   input  tgtsel_t itr_tgtsel_i,
   output logic    itr_ack_o,
   output logic    itr_err_o,
   output logic    itr_rty_o,
   output logic    itr_stall_o,
   output dat_t    itr_dat_o,
   // target side
   output logic    tgt_cyc_o,
   output logic    tgt_stb_o,
   output logic    tgt_we_o,
   output sel_t    tgt_sel_o,
   output adr_t    tgt_adr_o,
   output dat_t    tgt_dat_o,
   output tgtsel_t tgt_tgtsel_o,
   input  logic    tgt_ack_i,
   input  logic    tgt_err_i,
   input  logic    tgt_rty_i,
   input  logic    tgt_stall_i,
   input  dat_t    tgt_dat_i
);

   req_kind_t req_kind;               // class of current cycle
   logic      fwd_accept;             // to tracker
   logic      inval_accept;           // to response merge
   logic      busy;                   // from tracker
   logic      full;

   // --------------------
   // input stage
   // --------------------
   wb_req_decode wb_req_decode_i (
      .itr_cyc_i      (itr_cyc_i),
      .itr_stb_i      (itr_stb_i),
      .itr_we_i       (itr_we_i),
      .itr_sel_i      (itr_sel_i),
      .itr_adr_i      (itr_adr_i),
      .itr_dat_i      (itr_dat_i),
      .itr_tgtsel_i   (itr_tgtsel_i),
      .tgt_stall_i    (tgt_stall_i),
      .busy_i         (busy),
      .full_i         (full),
      .req_kind_o     (req_kind),
      .fwd_accept_o   (fwd_accept),
      .inval_accept_o (inval_accept),
      .itr_stall_o    (itr_stall_o),
      .tgt_cyc_o      (tgt_cyc_o),
      .tgt_stb_o      (tgt_stb_o),
      .tgt_we_o       (tgt_we_o),
      .tgt_sel_o      (tgt_sel_o),
      .tgt_adr_o      (tgt_adr_o),
      .tgt_dat_o      (tgt_dat_o),
      .tgt_tgtsel_o   (tgt_tgtsel_o)
   );

   // --------------------
   // outstanding count
   // --------------------
   wb_out_tracker wb_out_tracker_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_kind_i   (req_kind),
      .fwd_accept_i (fwd_accept),
      .tgt_ack_i    (tgt_ack_i),
      .tgt_err_i    (tgt_err_i),
      .tgt_rty_i    (tgt_rty_i),
      .busy_o       (busy),
      .full_o       (full)
   );

   // --------------------
   // output stage
   // --------------------
   wb_rsp_merge wb_rsp_merge_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req_kind_i     (req_kind),
      .inval_accept_i (inval_accept),
      .tgt_ack_i      (tgt_ack_i),
      .tgt_err_i      (tgt_err_i),
      .tgt_rty_i      (tgt_rty_i),
      .tgt_dat_i      (tgt_dat_i),
      .itr_ack_o      (itr_ack_o),
      .itr_err_o      (itr_err_o),
      .itr_rty_o      (itr_rty_o),
      .itr_dat_o      (itr_dat_o)
   );

endmodule

`default_nettype wire

// ==== tb_wb_err_gen.sv ====
/*
 * directed testbench for the error generator, the target is modeled by tasks
 * inputs change 2 ns after the rising edge, outputs are read 18 ns after it
 */
`default_nettype none

`include "err_gen_consts.svh"

module tb_wb_err_gen
   import wb_bus_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   // rough cycle budget: reset, then each test in run order
   localparam int TEST_CYCLES = 3 + 3 + 5 + 8 + 13 + 13 + 10;

   logic    clk_i;
   logic    rst_i;
   logic    itr_cyc, itr_stb, itr_we;
   sel_t    itr_sel;
   adr_t    itr_adr;
   dat_t    itr_dat;
   tgtsel_t itr_tgtsel;
   logic    itr_ack_o, itr_err_o, itr_rty_o, itr_stall_o;
   dat_t    itr_dat_o;
   logic    tgt_cyc_o, tgt_stb_o, tgt_we_o;
   sel_t    tgt_sel_o;
   adr_t    tgt_adr_o;
   dat_t    tgt_dat_o;
   tgtsel_t tgt_tgtsel_o;
   logic    tgt_ack, tgt_err, tgt_rty, tgt_stall;
   dat_t    tgt_dat;

   integer  seed = 41160;             // fixed seed for $random
   int      err_cnt  = 0;             // value mismatches and timeouts
   int      pass_cnt = 0;
   int      fail_cnt = 0;

   wb_err_gen wb_err_gen_i (
      .clk_i (clk_i), .rst_i (rst_i),
      .itr_cyc_i (itr_cyc), .itr_stb_i (itr_stb), .itr_we_i (itr_we),
      .itr_sel_i (itr_sel), .itr_adr_i (itr_adr), .itr_dat_i (itr_dat),
      .itr_tgtsel_i (itr_tgtsel),
      .itr_ack_o (itr_ack_o), .itr_err_o (itr_err_o), .itr_rty_o (itr_rty_o),
      .itr_stall_o (itr_stall_o), .itr_dat_o (itr_dat_o),
      .tgt_cyc_o (tgt_cyc_o), .tgt_stb_o (tgt_stb_o), .tgt_we_o (tgt_we_o),
      .tgt_sel_o (tgt_sel_o), .tgt_adr_o (tgt_adr_o), .tgt_dat_o (tgt_dat_o),
      .tgt_tgtsel_o (tgt_tgtsel_o),
      .tgt_ack_i (tgt_ack), .tgt_err_i (tgt_err), .tgt_rty_i (tgt_rty),
      .tgt_stall_i (tgt_stall), .tgt_dat_i (tgt_dat)
   );

   always #20 clk_i = ~clk_i;         // 40 ns period

   // --------------------
   // timing and bus helpers
   // --------------------
   task automatic next_cycle();
      @(posedge clk_i);
      #2;                             // drive point
   endtask

   task automatic settle();
      #16;                            // read point, well before next edge
   endtask

   task automatic drive_req(input logic we, input adr_t adr, input dat_t dat,
                            input sel_t sel, input tgtsel_t tgt);
      itr_cyc    = 1'b1;
      itr_stb    = 1'b1;
      itr_we     = we;
      itr_adr    = adr;
      itr_dat    = dat;
      itr_sel    = sel;
      itr_tgtsel = tgt;
   endtask

   task automatic drop_stb();
      itr_stb = 1'b0;                 // cyc held, responses still owed
   endtask

   task automatic target_rsp(input logic ack, input logic err, input logic rty,
                             input dat_t dat);
      tgt_ack = ack;
      tgt_err = err;
      tgt_rty = rty;
      tgt_dat = dat;
   endtask

   task automatic target_idle();
      target_rsp(1'b0, 1'b0, 1'b0, 16'hffff);   // junk data on idle bus
   endtask

   task automatic idle_cycle();
      itr_cyc = 1'b0;
      itr_stb = 1'b0;
      settle();
      next_cycle();
   endtask

   function automatic tgtsel_t one_hot_tag();
      int idx;
      idx = $unsigned($random(seed)) % `TGT_CNT;
      return tgtsel_t'(1) << idx;
   endfunction

   // waits in the read phase until stall drops, returns at the read point
   task automatic wait_accept(input int max_cycles);
      int n;
      n = 0;
      settle();
      while (itr_stall_o !== 1'b0 && n < max_cycles)
      begin
         next_cycle();
         settle();
         n++;
      end
      if (itr_stall_o !== 1'b0)
      begin
         $display("request still stalled after %0d cycles at %0t ns", max_cycles, $time);
         err_cnt++;
      end
   endtask

   // --------------------
   // compare tasks
   // --------------------
   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_dat(input dat_t got, input dat_t exp, input string what);
      if (got !== exp)
      begin
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_req(input adr_t adr, input sel_t sel, input tgtsel_t tgt,
                            input adr_t exp_adr, input sel_t exp_sel,
                            input tgtsel_t exp_tgt);
      if (adr !== exp_adr || sel !== exp_sel || tgt !== exp_tgt)
      begin
         $display("ERR %0t ns: forwarded adr/sel/tag %h/%b/%b, expected %h/%b/%b",
                  $time, adr, sel, tgt, exp_adr, exp_sel, exp_tgt);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_cnt == errs_before)
      begin
         $display("test %-14s ok", name);
         pass_cnt++;
      end
      else
      begin
         $display("test %-14s FAIL (%0d errors)", name, err_cnt - errs_before);
         fail_cnt++;
      end
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic test_reset();
      int e0;
      e0 = err_cnt;
      repeat (3)
      begin
         settle();
         check_bit(tgt_cyc_o, 1'b0, "tgt_cyc_o idle");
         check_bit(tgt_stb_o, 1'b0, "tgt_stb_o idle");
         check_bit(itr_err_o, 1'b0, "itr_err_o idle");
         check_bit(itr_stall_o, 1'b0, "itr_stall_o idle");
         next_cycle();
      end
      report_test("reset", e0);
   endtask

   task automatic test_pass_through();
      int      e0;
      logic    we;
      adr_t    adr;
      dat_t    wdat;
      dat_t    rdat;
      sel_t    sel;
      tgtsel_t tgt;
      e0 = err_cnt;
      for (int i = 0; i < 2; i++)
      begin
         we   = (i == 0);                                // write, then read
         adr  = adr_t'($random(seed));
         wdat = dat_t'($random(seed));
         sel  = sel_t'($random(seed));
         tgt  = one_hot_tag();
         drive_req(we, adr, wdat, sel, tgt);
         settle();
         check_bit(tgt_cyc_o, 1'b1, "tgt_cyc_o forwarded");
         check_bit(tgt_stb_o, 1'b1, "tgt_stb_o forwarded");
         check_bit(tgt_we_o, we, "tgt_we_o forwarded");
         check_bit(itr_stall_o, 1'b0, "itr_stall_o on free target");
         check_req(tgt_adr_o, tgt_sel_o, tgt_tgtsel_o, adr, sel, tgt);
         check_dat(tgt_dat_o, wdat, "tgt_dat_o forwarded");
         next_cycle();
         drop_stb();
         rdat = dat_t'($random(seed));
         target_rsp(1'b1, 1'b0, 1'b0, rdat);             // ack one cycle later
         settle();
         check_bit(itr_ack_o, 1'b1, "itr_ack_o passed back");
         check_dat(itr_dat_o, rdat, "itr_dat_o passed back");
         next_cycle();
         target_idle();
      end
      idle_cycle();
      report_test("pass-through", e0);
   endtask

   task automatic test_error_rsp();
      int e0;
      e0 = err_cnt;
      drive_req(1'b0, adr_t'($random(seed)), '0, 2'b11, '0);
      settle();
      check_bit(tgt_stb_o, 1'b0, "tgt_stb_o on zero tag");
      check_bit(itr_stall_o, 1'b0, "itr_stall_o on zero tag");
      check_bit(itr_err_o, 1'b0, "itr_err_o before accept");
      next_cycle();
      drop_stb();
      settle();
      check_bit(itr_err_o, 1'b1, "itr_err_o after accept");
      check_dat(itr_dat_o, '0, "itr_dat_o during err");
      next_cycle();
      settle();
      check_bit(itr_err_o, 1'b0, "itr_err_o one cycle only");
      next_cycle();
      // two invalid requests back to back
      drive_req(1'b1, adr_t'($random(seed)), dat_t'($random(seed)), 2'b01, '0);
      settle();
      check_bit(itr_stall_o, 1'b0, "itr_stall_o first zero tag");
      next_cycle();
      itr_adr = adr_t'($random(seed));                   // second request
      settle();
      check_bit(itr_err_o, 1'b1, "itr_err_o first request");
      check_bit(itr_stall_o, 1'b0, "itr_stall_o second zero tag");
      check_bit(tgt_stb_o, 1'b0, "tgt_stb_o second zero tag");
      next_cycle();
      drop_stb();
      settle();
      check_bit(itr_err_o, 1'b1, "itr_err_o second request");
      check_dat(itr_dat_o, '0, "itr_dat_o second err");
      next_cycle();
      settle();
      check_bit(itr_err_o, 1'b0, "itr_err_o after both");
      next_cycle();
      idle_cycle();
      report_test("error response", e0);
   endtask

   task automatic test_ordering();
      int   e0;
      dat_t rdat;
      e0 = err_cnt;
      drive_req(1'b0, adr_t'($random(seed)), '0, 2'b11, one_hot_tag());
      settle();
      check_bit(itr_stall_o, 1'b0, "itr_stall_o forwarded request");
      next_cycle();
      drive_req(1'b0, adr_t'($random(seed)), '0, 2'b11, '0);   // zero tag behind it
      repeat (2)
      begin
         settle();
         check_bit(itr_stall_o, 1'b1, "itr_stall_o zero tag while busy");
         check_bit(tgt_stb_o, 1'b0, "tgt_stb_o zero tag while busy");
         next_cycle();
      end
      rdat = dat_t'($random(seed));
      target_rsp(1'b1, 1'b0, 1'b0, rdat);
      settle();
      check_bit(itr_ack_o, 1'b1, "itr_ack_o outstanding request");
      check_dat(itr_dat_o, rdat, "itr_dat_o outstanding request");
      check_bit(itr_err_o, 1'b0, "itr_err_o before zero tag accept");
      next_cycle();
      target_idle();
      wait_accept(4);
      next_cycle();
      drop_stb();
      settle();
      check_bit(itr_err_o, 1'b1, "itr_err_o after ordered accept");
      check_dat(itr_dat_o, '0, "itr_dat_o ordered err");
      next_cycle();
      settle();
      check_bit(itr_err_o, 1'b0, "itr_err_o ordered err one cycle");
      next_cycle();
      idle_cycle();
      report_test("ordering", e0);
   endtask

   task automatic test_outstanding();
      int         e0;
      logic [2:0] rsp;
      dat_t       rdat;
      e0 = err_cnt;
      for (int i = 0; i < `MAX_OUTSTANDING; i++)
      begin
         drive_req(1'b1, adr_t'($random(seed)), dat_t'($random(seed)), 2'b11,
                   one_hot_tag());
         settle();
         check_bit(itr_stall_o, 1'b0, "itr_stall_o below limit");
         check_bit(tgt_stb_o, 1'b1, "tgt_stb_o below limit");
         next_cycle();
      end
      drive_req(1'b1, adr_t'($random(seed)), dat_t'($random(seed)), 2'b11,
                one_hot_tag());
      settle();
      check_bit(itr_stall_o, 1'b1, "itr_stall_o at limit");
      check_bit(tgt_stb_o, 1'b0, "tgt_stb_o at limit");
      next_cycle();
      target_rsp(1'b1, 1'b0, 1'b0, dat_t'($random(seed)));
      settle();
      check_bit(itr_stall_o, 1'b1, "itr_stall_o in ack cycle");
      check_bit(itr_ack_o, 1'b1, "itr_ack_o first drain");
      next_cycle();
      target_idle();
      settle();
      check_bit(itr_stall_o, 1'b0, "itr_stall_o after one ack");
      check_bit(tgt_stb_o, 1'b1, "tgt_stb_o after one ack");
      next_cycle();
      drop_stb();
      for (int j = 0; j < `MAX_OUTSTANDING; j++)
      begin
         rsp  = 3'b001 << (j % 3);                       // ack, err, rty in turn
         rdat = dat_t'($random(seed));
         target_rsp(rsp[0], rsp[1], rsp[2], rdat);
         settle();
         check_bit(itr_ack_o, rsp[0], "itr_ack_o drain");
         check_bit(itr_err_o, rsp[1], "itr_err_o drain");
         check_bit(itr_rty_o, rsp[2], "itr_rty_o drain");
         check_dat(itr_dat_o, rdat, "itr_dat_o drain");
         next_cycle();
      end
      target_idle();
      idle_cycle();
      report_test("outstanding", e0);
   endtask

   task automatic test_backpressure();
      int      e0;
      adr_t    adr;
      sel_t    sel;
      tgtsel_t tgt;
      dat_t    rdat;
      e0  = err_cnt;
      adr = adr_t'($random(seed));
      sel = sel_t'($random(seed));
      tgt = one_hot_tag();
      tgt_stall = 1'b1;
      drive_req(1'b1, adr, dat_t'($random(seed)), sel, tgt);
      repeat (2)
      begin
         settle();
         check_bit(itr_stall_o, 1'b1, "itr_stall_o follows target");
         check_bit(tgt_stb_o, 1'b1, "tgt_stb_o held under stall");
         check_req(tgt_adr_o, tgt_sel_o, tgt_tgtsel_o, adr, sel, tgt);
         next_cycle();
      end
      tgt_stall = 1'b0;
      wait_accept(4);
      next_cycle();
      drop_stb();
      rdat = dat_t'($random(seed));
      target_rsp(1'b1, 1'b0, 1'b0, rdat);
      settle();
      check_bit(itr_ack_o, 1'b1, "itr_ack_o after stall");
      check_dat(itr_dat_o, rdat, "itr_dat_o after stall");
      next_cycle();
      target_idle();
      idle_cycle();
      report_test("backpressure", e0);
   endtask

   // --------------------
   // run
   // --------------------
   initial
   begin
      clk_i      = 1'b0;
      rst_i      = 1'b1;
      itr_cyc    = 1'b0;
      itr_stb    = 1'b0;
      itr_we     = 1'b0;
      itr_sel    = '0;
      itr_adr    = '0;
      itr_dat    = '0;
      itr_tgtsel = '0;
      tgt_stall  = 1'b0;
      target_idle();
      repeat (3) @(posedge clk_i);
      #2 rst_i = 1'b0;
      test_reset();
      test_pass_through();
      test_error_rsp();
      test_ordering();
      test_outstanding();
      test_backpressure();
      $display("summary: %0d tests ok, %0d tests failing, %0d errors",
               pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // watchdog, twice the budgeted run time
   initial
   begin
      #(TEST_CYCLES * 40 * 2);
      $display("watchdog expired, the run did not finish in time");
      $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
wb_bus_pkg.sv
err_gen_pkg.sv
wb_req_decode.sv
wb_out_tracker.sv
wb_rsp_merge.sv
wb_err_gen.sv
tb_wb_err_gen.sv
